// File: phase_meas_pkg.sv
`default_nettype none

// sampling, delay line and phase counting definitions
package phase_meas_pkg;

	// one delay line entry per clock
	localparam int unsigned DELAY_DEPTH = 256;

	// delay line index, also the feedback delay setting u
	typedef logic [$clog2(DELAY_DEPTH)-1:0] delay_idx_t;

	// signed phase count, positive when voltage leads current
	typedef logic signed [8:0] theta_t;

	// counter ceiling, largest positive theta
	localparam theta_t THETA_MAX = 9'sd255;

	// age of the in-phase current tap, in clocks
	localparam int unsigned IS_TAP = 24;
	// quadrature tap, roughly a quarter period further back
	localparam int unsigned ISQ_TAP = 66;

endpackage

`default_nettype wire

// File: lock_ctrl_pkg.sv
`default_nettype none

// lock tracking and report handshake definitions
package lock_ctrl_pkg;

	typedef enum logic {
		UNLOCKED,
		LOCKED
	} lock_state_t;

	typedef enum logic [1:0] {
		IDLE,
		REQ_HIGH,
		WAIT_RELEASE
	} report_state_t;

	// hysteresis window on |theta|
	localparam int unsigned THETA_LOWER = 16;
	localparam int unsigned THETA_UPPER = 40;
	// no delay step inside this band
	localparam int unsigned TUNE_TOL = 5;

endpackage

`default_nettype wire

// File: input_sync.sv
`default_nettype none

module input_sync (
	input  logic clk10MHz_inv,
	input  logic rst_n,
	input  logic vq,
	input  logic iq,
	input  logic cycle,
	output logic vs,
	output logic iqs,
	output logic cycle_edge
);

	// two sync stages per input
	logic vq_s1;
	logic vq_s2;
	logic iq_s1;
	logic iq_s2;
	logic cycle_s1;
	logic cycle_s2;
	// previous synced cycle level for edge detect
	logic cycle_s3;

	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			vq_s1      <= 1'b0;
			vq_s2      <= 1'b0;
			vs         <= 1'b0;
			iq_s1      <= 1'b0;
			iq_s2      <= 1'b0;
			iqs        <= 1'b0;
			cycle_s1   <= 1'b0;
			cycle_s2   <= 1'b0;
			cycle_s3   <= 1'b0;
			cycle_edge <= 1'b0;
		end else begin
			vq_s1    <= vq;
			vq_s2    <= vq_s1;
			// third stage keeps vs in step with cycle_edge
			vs       <= vq_s2;
			iq_s1    <= iq;
			iq_s2    <= iq_s1;
			iqs      <= iq_s2;
			cycle_s1 <= cycle;
			cycle_s2 <= cycle_s1;
			cycle_s3 <= cycle_s2;
			// rising edge of the oscillator square wave, one clock wide
			cycle_edge <= cycle_s2 & ~cycle_s3;
		end
	end

endmodule

`default_nettype wire

// File: iq_delay_line.sv
`default_nettype none

module iq_delay_line (
	input  logic                       clk10MHz_inv,
	input  logic                       rst_n,
	input  logic                       iqs,
	input  phase_meas_pkg::delay_idx_t delay_u,
	output logic                       r,
	output logic                       is_i,
	output logic                       is_q
);

	import phase_meas_pkg::*;

	// circular history of the current sign
	logic [DELAY_DEPTH-1:0] line_q;
	delay_idx_t             wr_idx;
	delay_idx_t             fb_idx;
	delay_idx_t             tap_i_idx;
	delay_idx_t             tap_q_idx;
	logic                   fb_bit;

	// read indices wrap with the write index
	assign fb_idx    = wr_idx - delay_u;
	assign tap_i_idx = wr_idx - delay_idx_t'(IS_TAP);
	assign tap_q_idx = wr_idx - delay_idx_t'(ISQ_TAP);

	// zero age is not in the line yet, take it from the input
	assign fb_bit = (delay_u == '0) ? iqs : line_q[fb_idx];

	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			line_q <= '0;
			wr_idx <= '0;
			// cleared line means inverted feedback starts high
			r      <= 1'b1;
		end else begin
			line_q[wr_idx] <= iqs;
			wr_idx         <= wr_idx + 1'b1;
			// relay feedback closes the oscillator loop
			r              <= ~fb_bit;
		end
	end

	// fixed reference taps for the phase estimator
	assign is_i = line_q[tap_i_idx];
	assign is_q = line_q[tap_q_idx];

endmodule

`default_nettype wire

// File: phase_estimator.sv
`default_nettype none

module phase_estimator (
	input  logic                   clk10MHz_inv,
	input  logic                   rst_n,
	input  logic                   vs,
	input  logic                   is_i,
	input  logic                   is_q,
	input  logic                   cycle_edge,
	output phase_meas_pkg::theta_t theta,
	output logic                   theta_valid
);

	import phase_meas_pkg::*;

	// clocks of v/i mismatch this cycle
	theta_t cnt_i;
	// up on quadrature mismatch, down on match
	theta_t cnt_q;
	logic   mis_i;
	logic   mis_q;

	assign mis_i = vs ^ is_i;
	assign mis_q = vs ^ is_q;

	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			cnt_i       <= '0;
			cnt_q       <= '0;
			theta_valid <= 1'b0;
		end else begin
			theta_valid <= cycle_edge;
			if (cycle_edge) begin
				// new oscillator cycle
				cnt_i <= '0;
				cnt_q <= '0;
			end else begin
				if (mis_i && (cnt_i != THETA_MAX)) begin
					cnt_i <= cnt_i + 9'sd1;
				end
				// saturate both ways
				if (mis_q) begin
					if (cnt_q != THETA_MAX) begin
						cnt_q <= cnt_q + 9'sd1;
					end
				end else if (cnt_q != -THETA_MAX) begin
					cnt_q <= cnt_q - 9'sd1;
				end
			end
		end
	end

	// sign from the quadrature count, magnitude from the in-phase count
	always_ff @(posedge clk10MHz_inv) begin
		if (cycle_edge) begin
			theta <= cnt_q[8] ? -cnt_i : cnt_i;
		end
	end

endmodule

`default_nettype wire

// File: lock_tracker.sv
`default_nettype none

module lock_tracker (
	input  logic                       clk10MHz_inv,
	input  logic                       rst_n,
	input  phase_meas_pkg::theta_t     theta,
	input  logic                       theta_valid,
	output logic                       locked,
	output phase_meas_pkg::delay_idx_t delay_u
);

	import lock_ctrl_pkg::*;

	lock_state_t state;
	// |theta|, never -256 so nine bits hold it
	logic [8:0]  theta_mag;
	logic        enter_lock;
	logic        leave_lock;
	logic        step_en;

	assign theta_mag = theta[8] ? 9'(-theta) : 9'(theta);

	// hysteresis thresholds
	assign enter_lock = theta_mag < THETA_LOWER;
	assign leave_lock = theta_mag >= THETA_UPPER;
	// outside the dead zone
	assign step_en    = theta_mag > TUNE_TOL;

	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			state   <= UNLOCKED;
			delay_u <= '0;
		end else if (theta_valid) begin
			case (state)
				UNLOCKED: begin
					if (enter_lock) begin
						state <= LOCKED;
					end
				end
				LOCKED: begin
					if (leave_lock) begin
						state <= UNLOCKED;
					end
				end
			endcase
			// nudge feedback delay toward zero phase
			if (step_en) begin
				if (theta[8]) begin
					// current leads, shorten
					if (delay_u != '0) begin
						delay_u <= delay_u - 1'b1;
					end
				end else if (delay_u != '1) begin
					delay_u <= delay_u + 1'b1;
				end
			end
		end
	end

	assign locked = (state == LOCKED);

endmodule

`default_nettype wire

// File: phase_report.sv
`default_nettype none

module phase_report (
	input  logic                   clk10MHz_inv,
	input  logic                   rst_n,
	input  phase_meas_pkg::theta_t theta,
	input  logic                   theta_valid,
	input  logic                   locked,
	input  logic                   report_ack,
	output phase_meas_pkg::theta_t theta_report,
	output logic                   locked_report,
	output logic                   report_req
);

	import lock_ctrl_pkg::*;

	report_state_t state;
	logic          capture;

	// only take a sample when idle and the reader has released ack
	assign capture = (state == IDLE) && theta_valid && !report_ack;

	// four-phase handshake FSM
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (capture) begin
						state <= REQ_HIGH;
					end
				end
				REQ_HIGH: begin
					if (report_ack) begin
						state <= WAIT_RELEASE;
					end
				end
				WAIT_RELEASE: begin
					// wait for ack to drop before the next report
					if (!report_ack) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// held until the exchange completes, later samples are dropped
	always_ff @(posedge clk10MHz_inv) begin
		if (capture) begin
			theta_report  <= theta;
			locked_report <= locked;
		end
	end

	assign report_req = (state == REQ_HIGH);

endmodule

`default_nettype wire

// File: relay_feedback_osc.sv
`default_nettype none

module relay_feedback_osc (
	input  logic                       clk10MHz_inv,
	input  logic                       rst_n,
	input  logic                       vq,
	input  logic                       iq,
	input  logic                       cycle,
	input  logic                       report_ack,
	output logic                       r,
	output logic                       locked,
	output phase_meas_pkg::delay_idx_t delay_u,
	output phase_meas_pkg::theta_t     theta_report,
	output logic                       locked_report,
	output logic                       report_req
);

	// synced comparator signals and cycle start
	logic                   vs;
	logic                   iqs;
	logic                   cycle_edge;
	// reference current taps
	logic                   is_i;
	logic                   is_q;
	// one measurement per oscillator cycle
	phase_meas_pkg::theta_t theta;
	logic                   theta_valid;

	input_sync u_input_sync (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.vq           (vq),
		.iq           (iq),
		.cycle        (cycle),
		.vs           (vs),
		.iqs          (iqs),
		.cycle_edge   (cycle_edge)
	);

	iq_delay_line u_iq_delay_line (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.iqs          (iqs),
		.delay_u      (delay_u),
		.r            (r),
		.is_i         (is_i),
		.is_q         (is_q)
	);

	phase_estimator u_phase_estimator (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.vs           (vs),
		.is_i         (is_i),
		.is_q         (is_q),
		.cycle_edge   (cycle_edge),
		.theta        (theta),
		.theta_valid  (theta_valid)
	);

	// delay setting loops back into the delay line
	lock_tracker u_lock_tracker (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.theta        (theta),
		.theta_valid  (theta_valid),
		.locked       (locked),
		.delay_u      (delay_u)
	);

	phase_report u_phase_report (
		.clk10MHz_inv  (clk10MHz_inv),
		.rst_n         (rst_n),
		.theta         (theta),
		.theta_valid   (theta_valid),
		.locked        (locked),
		.report_ack    (report_ack),
		.theta_report  (theta_report),
		.locked_report (locked_report),
		.report_req    (report_req)
	);

endmodule

`default_nettype wire

// File: relay_feedback_osc_sva.sv
`default_nettype none

module relay_feedback_osc_sva (
	input logic                   clk10MHz_inv,
	input logic                   rst_n,
	input logic                   report_req,
	input logic                   report_ack,
	input phase_meas_pkg::theta_t theta_report
);
	timeunit 1ns;
	timeprecision 100ps;

	// req holds until the reader acks
	a_req_held: assert property (@(posedge clk10MHz_inv) disable iff (!rst_n)
		report_req && !report_ack |=> report_req)
		else $error("report_req fell before report_ack rose");

	// held data frozen during the exchange
	a_report_stable: assert property (@(posedge clk10MHz_inv) disable iff (!rst_n)
		report_req && $past(report_req) |-> $stable(theta_report))
		else $error("theta_report changed while report_req was high");

	// no new request until ack is released
	a_no_rise_on_ack: assert property (@(posedge clk10MHz_inv) disable iff (!rst_n)
		!report_req && report_ack |=> !report_req)
		else $error("report_req rose while report_ack was high");

endmodule

bind relay_feedback_osc relay_feedback_osc_sva u_relay_feedback_osc_sva (
	.clk10MHz_inv (clk10MHz_inv),
	.rst_n        (rst_n),
	.report_req   (report_req),
	.report_ack   (report_ack),
	.theta_report (theta_report)
);

`default_nettype wire

// File: tb_relay_feedback_osc.sv
`default_nettype none

module tb_relay_feedback_osc;
	timeunit 1ns;
	timeprecision 100ps;

	import phase_meas_pkg::*;
	import lock_ctrl_pkg::*;

	localparam int CLK_NS = 100;
	// oscillator period in clocks
	localparam int PERIOD = 200;
	localparam int HIST = 512;
	localparam int SAT = 255;
	// measurements per test with the tap test counted as six periods
	localparam int TEST_CYCLES = 12 + 8 + 9 + 6 + 7;
	localparam longint WATCHDOG_NS = longint'(TEST_CYCLES + 20) * PERIOD * CLK_NS;

	logic       clk10MHz_inv;
	logic       rst_n;
	logic       vq;
	logic       iq;
	logic       cycle;
	logic       report_ack;
	logic       r;
	logic       locked;
	delay_idx_t delay_u;
	theta_t     theta_report;
	logic       locked_report;
	logic       report_req;

	// waveform source control
	logic wave_on;
	logic iq_const;
	logic iq_level;
	int   iq_lead;
	int   t_wave;

	// reference model state
	logic [HIST-1:0] h_v;
	logic [HIST-1:0] h_i;
	logic [HIST-1:0] h_c;
	int   m_n;
	int   m_cnt_i;
	int   m_cnt_q;
	int   m_theta;
	logic m_locked;
	logic m_lock_prev;
	int   m_delay;
	int   m_meas_n;

	int checks;
	int errors;
	logic [31:0] lfsr_state = 32'd96173;

	relay_feedback_osc u_relay_feedback_osc (
		.clk10MHz_inv  (clk10MHz_inv),
		.rst_n         (rst_n),
		.vq            (vq),
		.iq            (iq),
		.cycle         (cycle),
		.report_ack    (report_ack),
		.r             (r),
		.locked        (locked),
		.delay_u       (delay_u),
		.theta_report  (theta_report),
		.locked_report (locked_report),
		.report_req    (report_req)
	);

	initial begin
		clk10MHz_inv = 1'b0;
		forever #(CLK_NS / 2) clk10MHz_inv = ~clk10MHz_inv;
	end

	// galois lfsr stepped once per bit taken
	function automatic int unsigned take_bits(int n);
		int unsigned v;
		v = 0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
			v = (v << 1) | lfsr_state[0];
		end
		return v;
	endfunction

	function automatic logic square(int t);
		return (t % PERIOD) < (PERIOD / 2);
	endfunction

	// history index that also covers clocks before reset release
	function automatic int wrap(int idx);
		return ((idx % HIST) + HIST) % HIST;
	endfunction

	// vq and cycle share one square wave while iq leads by iq_lead
	always @(posedge clk10MHz_inv) begin
		if (wave_on) begin
			cycle  <= square(t_wave);
			vq     <= square(t_wave);
			t_wave <= t_wave + 1;
		end
		iq <= iq_const ? iq_level : square(t_wave + iq_lead);
	end

	// one model step per active clock using pin values of the past clock
	task automatic model_clock();
		int   k;
		int   mag;
		logic cyc_rise;
		logic v;
		logic i_tap;
		logic q_tap;
		m_n = m_n + 1;
		k = m_n;
		h_v[wrap(k)] = vq;
		h_i[wrap(k)] = iq;
		h_c[wrap(k)] = cycle;
		// three clocks of input path plus the tap ages
		cyc_rise = h_c[wrap(k - 3)] & ~h_c[wrap(k - 4)];
		v = h_v[wrap(k - 3)];
		i_tap = h_i[wrap(k - 3 - int'(IS_TAP))];
		q_tap = h_i[wrap(k - 3 - int'(ISQ_TAP))];
		if (cyc_rise) begin
			m_theta = (m_cnt_q < 0) ? -m_cnt_i : m_cnt_i;
			mag = (m_theta < 0) ? -m_theta : m_theta;
			// report carries lock state from before this update
			m_lock_prev = m_locked;
			if (!m_locked && mag < int'(THETA_LOWER)) begin
				m_locked = 1'b1;
			end else if (m_locked && mag >= int'(THETA_UPPER)) begin
				m_locked = 1'b0;
			end
			if (mag > int'(TUNE_TOL)) begin
				if (m_theta < 0 && m_delay > 0) begin
					m_delay = m_delay - 1;
				end else if (m_theta > 0 && m_delay < SAT) begin
					m_delay = m_delay + 1;
				end
			end
			m_meas_n = m_meas_n + 1;
			m_cnt_i = 0;
			m_cnt_q = 0;
		end else begin
			if (v != i_tap && m_cnt_i < SAT) begin
				m_cnt_i = m_cnt_i + 1;
			end
			if (v != q_tap) begin
				if (m_cnt_q < SAT) begin
					m_cnt_q = m_cnt_q + 1;
				end
			end else if (m_cnt_q > -SAT) begin
				m_cnt_q = m_cnt_q - 1;
			end
		end
	endtask

	always @(posedge clk10MHz_inv) begin
		if (rst_n) begin
			model_clock();
		end
	end

	task automatic check_theta(string name, theta_t got, theta_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_delay(string name, delay_idx_t got, delay_idx_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// snapshot of the model when req first shows up
	task automatic wait_req(output theta_t th, output logic lk, output bit ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < 2 * PERIOD + 20) begin
			@(negedge clk10MHz_inv);
			ok = (report_req === 1'b1);
			n++;
		end
		if (!ok) begin
			errors++;
			$display("no report request within %0d clocks at %0t", n, $time);
		end
		th = theta_t'(m_theta);
		lk = m_lock_prev;
	endtask

	// ack and expect req to drop one clock later before releasing ack
	task automatic release_req();
		@(posedge clk10MHz_inv);
		report_ack <= 1'b1;
		@(posedge clk10MHz_inv);
		@(negedge clk10MHz_inv);
		check_bit("report_req", report_req, 1'b0);
		@(posedge clk10MHz_inv);
		report_ack <= 1'b0;
		@(negedge clk10MHz_inv);
	endtask

	task automatic read_report();
		theta_t th;
		logic   lk;
		bit     ok;
		int     ack_wait;
		wait_req(th, lk, ok);
		if (ok) begin
			check_theta("theta_report", theta_report, th);
			check_bit("locked_report", locked_report, lk);
			// reader answers after a random delay
			ack_wait = take_bits(3);
			repeat (ack_wait) @(posedge clk10MHz_inv);
			release_req();
			check_bit("locked", locked, m_locked);
			check_delay("delay_u", delay_u, delay_idx_t'(m_delay));
		end
	endtask

	task automatic reset_check();
		@(negedge clk10MHz_inv);
		check_bit("report_req", report_req, 1'b0);
		check_bit("locked", locked, 1'b0);
		check_delay("delay_u", delay_u, delay_idx_t'(0));
		check_bit("r", r, 1'b1);
	endtask

	task automatic random_phase_test();
		wave_on = 1'b1;
		iq_const = 1'b0;
		for (int i = 0; i < 4; i++) begin
			iq_lead = take_bits(8) % PERIOD;
			repeat (3) read_report();
		end
	endtask

	// lead of IS_TAP puts is_i exactly on vs
	task automatic lock_hysteresis_test();
		iq_lead = int'(IS_TAP);
		repeat (3) read_report();
		check_bit("locked", locked, 1'b1);
		// about 24 clocks apart and inside the window
		iq_lead = int'(IS_TAP) + 12;
		repeat (3) read_report();
		check_bit("locked", locked, 1'b1);
		iq_lead = int'(IS_TAP) + 30;
		repeat (2) read_report();
		check_bit("locked", locked, 1'b0);
	endtask

	task automatic delay_step_test();
		int d;
		// dead zone with theta near 4
		iq_lead = int'(IS_TAP) + 2;
		read_report();
		d = m_delay;
		repeat (2) read_report();
		check_delay("delay_u", delay_u, delay_idx_t'(d));
		// positive theta
		iq_lead = int'(IS_TAP) - 14;
		read_report();
		d = m_delay;
		repeat (2) read_report();
		check_delay("delay_u", delay_u, delay_idx_t'((d + 2 > SAT) ? SAT : d + 2));
		// negative theta
		iq_lead = int'(IS_TAP) + 12;
		read_report();
		d = m_delay;
		repeat (2) read_report();
		check_delay("delay_u", delay_u, delay_idx_t'((d < 2) ? 0 : d - 2));
	endtask

	task automatic feedback_tap_test();
		int   u;
		logic exp_r;
		wave_on = 1'b0;
		iq_const = 1'b1;
		iq_level = 1'b1;
		// let a pending measurement settle delay_u
		repeat (10) @(negedge clk10MHz_inv);
		u = m_delay;
		repeat (3) begin
			repeat (u + 10) begin
				@(negedge clk10MHz_inv);
				exp_r = ~h_i[wrap(m_n - 3 - u)];
				check_bit("r", r, exp_r);
			end
			iq_level = ~iq_level;
		end
	endtask

	task automatic backpressure_test();
		theta_t th;
		logic   lk;
		bit     ok;
		int     start;
		int     n;
		wave_on = 1'b1;
		iq_const = 1'b0;
		iq_lead = int'(IS_TAP) + 20;
		read_report();
		wait_req(th, lk, ok);
		if (ok) begin
			// later measurements carry a different theta than the held one
			iq_lead = int'(IS_TAP) + 6;
			start = m_meas_n;
			n = 0;
			// three more measurements arrive while ack is held back
			while (m_meas_n < start + 3 && n < 4 * PERIOD + 20) begin
				@(negedge clk10MHz_inv);
				n++;
			end
			if (m_meas_n < start + 3) begin
				errors++;
				$display("measurements stopped while report was held at %0t", $time);
			end
			check_bit("report_req", report_req, 1'b1);
			check_theta("theta_report", theta_report, th);
			check_bit("locked_report", locked_report, lk);
			release_req();
			// next report is a fresh measurement
			read_report();
		end
	endtask

	initial begin
		rst_n = 1'b0;
		vq = 1'b0;
		iq = 1'b0;
		cycle = 1'b0;
		report_ack = 1'b0;
		wave_on = 1'b0;
		iq_const = 1'b1;
		iq_level = 1'b0;
		iq_lead = 0;
		t_wave = 0;
		h_v = '0;
		h_i = '0;
		h_c = '0;
		m_n = 0;
		m_cnt_i = 0;
		m_cnt_q = 0;
		m_theta = 0;
		m_locked = 1'b0;
		m_lock_prev = 1'b0;
		m_delay = 0;
		m_meas_n = 0;
		checks = 0;
		errors = 0;
		repeat (2) @(posedge clk10MHz_inv);
		rst_n <= 1'b1;
		reset_check();
		random_phase_test();
		lock_hysteresis_test();
		delay_step_test();
		feedback_tap_test();
		backpressure_test();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// bounded by the summed test lengths
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: relay_feedback_osc.f
phase_meas_pkg.sv
lock_ctrl_pkg.sv
input_sync.sv
iq_delay_line.sv
phase_estimator.sv
lock_tracker.sv
phase_report.sv
relay_feedback_osc.sv
relay_feedback_osc_sva.sv
tb_relay_feedback_osc.sv

// File: Bender.yml
package:
  name: relay_feedback_osc

sources:
  - phase_meas_pkg.sv
  - lock_ctrl_pkg.sv
  - input_sync.sv
  - iq_delay_line.sv
  - phase_estimator.sv
  - lock_tracker.sv
  - phase_report.sv
  - relay_feedback_osc.sv
  - target: test
    files:
      - relay_feedback_osc_sva.sv
      - tb_relay_feedback_osc.sv
